// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_mem_subsys
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
mem_pkg.sv
axi_arbiter.sv
axi_sram.sv
mem_subsys.sv
tb_checker.sv
tb_mem_subsys.sv

// ==== axi_arbiter.sv ====
`timescale 1ns/100ps

module axi_arbiter
    import mem_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              rst,

    // Instruction fetch port
    input  logic              s1_axi_aw_valid_i,
    input  logic [ADDR_W-1:0] s1_axi_aw_addr_i,
    output logic              s1_axi_aw_ready_o,
    input  logic              s1_axi_w_valid_i,
    input  logic [DATA_W-1:0] s1_axi_w_data_i,
    input  logic [DATA_W/8-1:0] s1_axi_w_strb_i,
    output logic              s1_axi_w_ready_o,
    input  logic              s1_axi_b_ready_i,
    output logic              s1_axi_b_valid_o,
    output resp_t             s1_axi_b_resp_o,
    input  logic              s1_axi_ar_valid_i,
    input  logic [ADDR_W-1:0] s1_axi_ar_addr_i,
    output logic              s1_axi_ar_ready_o,
    input  logic              s1_axi_r_ready_i,
    output logic              s1_axi_r_valid_o,
    output resp_t             s1_axi_r_resp_o,
    output logic [DATA_W-1:0] s1_axi_r_data_o,

    // Load/store port
    input  logic              s2_axi_aw_valid_i,
    input  logic [ADDR_W-1:0] s2_axi_aw_addr_i,
    output logic              s2_axi_aw_ready_o,
    input  logic              s2_axi_w_valid_i,
    input  logic [DATA_W-1:0] s2_axi_w_data_i,
    input  logic [DATA_W/8-1:0] s2_axi_w_strb_i,
    output logic              s2_axi_w_ready_o,
    input  logic              s2_axi_b_ready_i,
    output logic              s2_axi_b_valid_o,
    output resp_t             s2_axi_b_resp_o,
    input  logic              s2_axi_ar_valid_i,
    input  logic [ADDR_W-1:0] s2_axi_ar_addr_i,
    output logic              s2_axi_ar_ready_o,
    input  logic              s2_axi_r_ready_i,
    output logic              s2_axi_r_valid_o,
    output resp_t             s2_axi_r_resp_o,
    output logic [DATA_W-1:0] s2_axi_r_data_o,

    // Toward the SRAM
    output logic              m_axi_aw_valid_o,
    output logic [ADDR_W-1:0] m_axi_aw_addr_o,
    input  logic              m_axi_aw_ready_i,
    output logic              m_axi_w_valid_o,
    output logic [DATA_W-1:0] m_axi_w_data_o,
    output logic [DATA_W/8-1:0] m_axi_w_strb_o,
    input  logic              m_axi_w_ready_i,
    output logic              m_axi_b_ready_o,
    input  logic              m_axi_b_valid_i,
    input  resp_t             m_axi_b_resp_i,
    output logic              m_axi_ar_valid_o,
    output logic [ADDR_W-1:0] m_axi_ar_addr_o,
    input  logic              m_axi_ar_ready_i,
    output logic              m_axi_r_ready_o,
    input  logic              m_axi_r_valid_i,
    input  resp_t             m_axi_r_resp_i,
    input  logic [DATA_W-1:0] m_axi_r_data_i
);

    localparam int STRB_W = DATA_W / 8;

    arb_state_t rd_state;
    arb_state_t rd_next;
    arb_state_t wr_state;
    arb_state_t wr_next;
    logic       rd_last_s1;
    logic       wr_last_s1;
    logic       rd_s1, rd_s2, wr_s1, wr_s2;
    logic       rd_done, wr_done;

    // Round robin on ties, grant held until the response handshake
    function automatic arb_state_t next_grant(
        input arb_state_t state,
        input logic       last_s1,
        input logic       req1,
        input logic       req2,
        input logic       done
    );
        arb_state_t nxt;
        nxt = state;
        case (state)
            ARB_IDLE: begin
                if (req1 && req2) begin
                    nxt = last_s1 ? ARB_S2 : ARB_S1;
                end else if (req1) begin
                    nxt = ARB_S1;
                end else if (req2) begin
                    nxt = ARB_S2;
                end
            end
            ARB_S1: begin
                if (done) begin
                    nxt = req2 ? ARB_S2 : ARB_IDLE;
                end
            end
            ARB_S2: begin
                if (done) begin
                    nxt = req1 ? ARB_S1 : ARB_IDLE;
                end
            end
            default: nxt = ARB_IDLE;
        endcase
        return nxt;
    endfunction

    assign rd_done = m_axi_r_valid_i && m_axi_r_ready_o;
    assign wr_done = m_axi_b_valid_i && m_axi_b_ready_o;

    assign rd_next = next_grant(rd_state, rd_last_s1, s1_axi_ar_valid_i,
                                s2_axi_ar_valid_i, rd_done);
    assign wr_next = next_grant(wr_state, wr_last_s1, s1_axi_aw_valid_i,
                                s2_axi_aw_valid_i, wr_done);

    // s1 counts as served last out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state   <= ARB_IDLE;
            wr_state   <= ARB_IDLE;
            rd_last_s1 <= 1'b1;
            wr_last_s1 <= 1'b1;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
            if (rd_done) begin
                rd_last_s1 <= (rd_state == ARB_S1);
            end
            if (wr_done) begin
                wr_last_s1 <= (wr_state == ARB_S1);
            end
        end
    end

    assign rd_s1 = (rd_state == ARB_S1);
    assign rd_s2 = (rd_state == ARB_S2);
    assign wr_s1 = (wr_state == ARB_S1);
    assign wr_s2 = (wr_state == ARB_S2);

    // Read path
    assign m_axi_ar_valid_o  = (rd_s1 && s1_axi_ar_valid_i) || (rd_s2 && s2_axi_ar_valid_i);
    assign m_axi_ar_addr_o   = rd_s2 ? s2_axi_ar_addr_i : s1_axi_ar_addr_i;
    assign s1_axi_ar_ready_o = rd_s1 && m_axi_ar_ready_i;
    assign s2_axi_ar_ready_o = rd_s2 && m_axi_ar_ready_i;
    assign m_axi_r_ready_o   = (rd_s1 && s1_axi_r_ready_i) || (rd_s2 && s2_axi_r_ready_i);
    assign s1_axi_r_valid_o  = rd_s1 && m_axi_r_valid_i;
    assign s1_axi_r_resp_o   = rd_s1 ? m_axi_r_resp_i : RESP_OKAY;
    assign s1_axi_r_data_o   = rd_s1 ? m_axi_r_data_i : '0;
    assign s2_axi_r_valid_o  = rd_s2 && m_axi_r_valid_i;
    assign s2_axi_r_resp_o   = rd_s2 ? m_axi_r_resp_i : RESP_OKAY;
    assign s2_axi_r_data_o   = rd_s2 ? m_axi_r_data_i : '0;

    // Write path, AW and W follow the same grant
    assign m_axi_aw_valid_o  = (wr_s1 && s1_axi_aw_valid_i) || (wr_s2 && s2_axi_aw_valid_i);
    assign m_axi_aw_addr_o   = wr_s2 ? s2_axi_aw_addr_i : s1_axi_aw_addr_i;
    assign s1_axi_aw_ready_o = wr_s1 && m_axi_aw_ready_i;
    assign s2_axi_aw_ready_o = wr_s2 && m_axi_aw_ready_i;
    assign m_axi_w_valid_o   = (wr_s1 && s1_axi_w_valid_i) || (wr_s2 && s2_axi_w_valid_i);
    assign m_axi_w_data_o    = wr_s2 ? s2_axi_w_data_i : s1_axi_w_data_i;
    assign m_axi_w_strb_o    = wr_s2 ? s2_axi_w_strb_i : STRB_W'(s1_axi_w_strb_i);
    assign s1_axi_w_ready_o  = wr_s1 && m_axi_w_ready_i;
    assign s2_axi_w_ready_o  = wr_s2 && m_axi_w_ready_i;
    assign m_axi_b_ready_o   = (wr_s1 && s1_axi_b_ready_i) || (wr_s2 && s2_axi_b_ready_i);
    assign s1_axi_b_valid_o  = wr_s1 && m_axi_b_valid_i;
    assign s1_axi_b_resp_o   = wr_s1 ? m_axi_b_resp_i : RESP_OKAY;
    assign s2_axi_b_valid_o  = wr_s2 && m_axi_b_valid_i;
    assign s2_axi_b_resp_o   = wr_s2 ? m_axi_b_resp_i : RESP_OKAY;

endmodule

// ==== axi_sram.sv ====
`timescale 1ns/100ps

module axi_sram
    import mem_pkg::*;
#(
    parameter int ADDR_W    = ADDR_W_DEF,
    parameter int DATA_W    = DATA_W_DEF,
    parameter int MEM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                s_axi_aw_valid_i,
    input  logic [ADDR_W-1:0]   s_axi_aw_addr_i,
    output logic                s_axi_aw_ready_o,
    input  logic                s_axi_w_valid_i,
    input  logic [DATA_W-1:0]   s_axi_w_data_i,
    input  logic [DATA_W/8-1:0] s_axi_w_strb_i,
    output logic                s_axi_w_ready_o,
    output logic                s_axi_b_valid_o,
    output resp_t               s_axi_b_resp_o,
    input  logic                s_axi_b_ready_i,
    input  logic                s_axi_ar_valid_i,
    input  logic [ADDR_W-1:0]   s_axi_ar_addr_i,
    output logic                s_axi_ar_ready_o,
    output logic                s_axi_r_valid_o,
    output resp_t               s_axi_r_resp_o,
    output logic [DATA_W-1:0]   s_axi_r_data_o,
    input  logic                s_axi_r_ready_i
);

    localparam int STRB_W = DATA_W / 8;
    localparam int OFFS_W = $clog2(STRB_W);
    localparam int IDX_W  = ADDR_W - OFFS_W;
    localparam int MEM_AW = $clog2(MEM_DEPTH);

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_ok, rd_ok;
    logic             wr_go, rd_go;

    // Byte address, word index above the byte offset
    assign wr_idx = s_axi_aw_addr_i[ADDR_W-1:OFFS_W];
    assign rd_idx = s_axi_ar_addr_i[ADDR_W-1:OFFS_W];
    assign wr_ok  = wr_idx < IDX_W'(MEM_DEPTH);
    assign rd_ok  = rd_idx < IDX_W'(MEM_DEPTH);

    // AW and W accepted together, one response outstanding per path
    assign wr_go = s_axi_aw_valid_i && s_axi_w_valid_i && !s_axi_b_valid_o;
    assign rd_go = s_axi_ar_valid_i && !s_axi_r_valid_o;

    assign s_axi_aw_ready_o = wr_go;
    assign s_axi_w_ready_o  = wr_go;
    assign s_axi_ar_ready_o = !s_axi_r_valid_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axi_b_valid_o <= 1'b0;
            s_axi_r_valid_o <= 1'b0;
        end else begin
            if (wr_go) begin
                s_axi_b_valid_o <= 1'b1;
            end else if (s_axi_b_ready_i) begin
                s_axi_b_valid_o <= 1'b0;
            end
            if (rd_go) begin
                s_axi_r_valid_o <= 1'b1;
            end else if (s_axi_r_ready_i) begin
                s_axi_r_valid_o <= 1'b0;
            end
        end
    end

    // Out-of-range writes are dropped
    always_ff @(posedge clk) begin
        if (wr_go && wr_ok) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (s_axi_w_strb_i[i]) begin
                    mem[wr_idx[MEM_AW-1:0]][i*8 +: 8] <= s_axi_w_data_i[i*8 +: 8];
                end
            end
        end
    end

    // Response payload, held while valid waits for ready
    always_ff @(posedge clk) begin
        if (wr_go) begin
            s_axi_b_resp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_go) begin
            s_axi_r_resp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            s_axi_r_data_o <= rd_ok ? mem[rd_idx[MEM_AW-1:0]] : '0;
        end
    end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    // Default bus widths, overridden from the subsystem top
    localparam int ADDR_W_DEF = 32;
    localparam int DATA_W_DEF = 64;

    // AXI4-Lite response codes used by the SRAM
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_t;

    // Grant state, shared by the read and write arbiters
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_S1   = 2'd1,
        ARB_S2   = 2'd2
    } arb_state_t;

endpackage

// ==== mem_subsys.sv ====
`timescale 1ns/100ps

module mem_subsys
    import mem_pkg::*;
#(
    parameter int ADDR_W    = ADDR_W_DEF,
    parameter int DATA_W    = DATA_W_DEF,
    parameter int MEM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                rst,

    // Instruction fetch port
    input  logic                s1_axi_aw_valid_i,
    input  logic [ADDR_W-1:0]   s1_axi_aw_addr_i,
    output logic                s1_axi_aw_ready_o,
    input  logic                s1_axi_w_valid_i,
    input  logic [DATA_W-1:0]   s1_axi_w_data_i,
    input  logic [DATA_W/8-1:0] s1_axi_w_strb_i,
    output logic                s1_axi_w_ready_o,
    input  logic                s1_axi_b_ready_i,
    output logic                s1_axi_b_valid_o,
    output resp_t               s1_axi_b_resp_o,
    input  logic                s1_axi_ar_valid_i,
    input  logic [ADDR_W-1:0]   s1_axi_ar_addr_i,
    output logic                s1_axi_ar_ready_o,
    input  logic                s1_axi_r_ready_i,
    output logic                s1_axi_r_valid_o,
    output resp_t               s1_axi_r_resp_o,
    output logic [DATA_W-1:0]   s1_axi_r_data_o,

    // Load/store port
    input  logic                s2_axi_aw_valid_i,
    input  logic [ADDR_W-1:0]   s2_axi_aw_addr_i,
    output logic                s2_axi_aw_ready_o,
    input  logic                s2_axi_w_valid_i,
    input  logic [DATA_W-1:0]   s2_axi_w_data_i,
    input  logic [DATA_W/8-1:0] s2_axi_w_strb_i,
    output logic                s2_axi_w_ready_o,
    input  logic                s2_axi_b_ready_i,
    output logic                s2_axi_b_valid_o,
    output resp_t               s2_axi_b_resp_o,
    input  logic                s2_axi_ar_valid_i,
    input  logic [ADDR_W-1:0]   s2_axi_ar_addr_i,
    output logic                s2_axi_ar_ready_o,
    input  logic                s2_axi_r_ready_i,
    output logic                s2_axi_r_valid_o,
    output resp_t               s2_axi_r_resp_o,
    output logic [DATA_W-1:0]   s2_axi_r_data_o
);

    // Arbiter to SRAM link
    logic                m_aw_valid, m_aw_ready;
    logic [ADDR_W-1:0]   m_aw_addr;
    logic                m_w_valid, m_w_ready;
    logic [DATA_W-1:0]   m_w_data;
    logic [DATA_W/8-1:0] m_w_strb;
    logic                m_b_valid, m_b_ready;
    resp_t               m_b_resp;
    logic                m_ar_valid, m_ar_ready;
    logic [ADDR_W-1:0]   m_ar_addr;
    logic                m_r_valid, m_r_ready;
    resp_t               m_r_resp;
    logic [DATA_W-1:0]   m_r_data;

    // Master ports keep their names through the arbiter
    axi_arbiter #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_arbiter (
        .m_axi_aw_valid_o (m_aw_valid),
        .m_axi_aw_addr_o  (m_aw_addr),
        .m_axi_aw_ready_i (m_aw_ready),
        .m_axi_w_valid_o  (m_w_valid),
        .m_axi_w_data_o   (m_w_data),
        .m_axi_w_strb_o   (m_w_strb),
        .m_axi_w_ready_i  (m_w_ready),
        .m_axi_b_ready_o  (m_b_ready),
        .m_axi_b_valid_i  (m_b_valid),
        .m_axi_b_resp_i   (m_b_resp),
        .m_axi_ar_valid_o (m_ar_valid),
        .m_axi_ar_addr_o  (m_ar_addr),
        .m_axi_ar_ready_i (m_ar_ready),
        .m_axi_r_ready_o  (m_r_ready),
        .m_axi_r_valid_i  (m_r_valid),
        .m_axi_r_resp_i   (m_r_resp),
        .m_axi_r_data_i   (m_r_data),
        .*
    );

    axi_sram #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_sram (
        .clk              (clk),
        .rst              (rst),
        .s_axi_aw_valid_i (m_aw_valid),
        .s_axi_aw_addr_i  (m_aw_addr),
        .s_axi_aw_ready_o (m_aw_ready),
        .s_axi_w_valid_i  (m_w_valid),
        .s_axi_w_data_i   (m_w_data),
        .s_axi_w_strb_i   (m_w_strb),
        .s_axi_w_ready_o  (m_w_ready),
        .s_axi_b_valid_o  (m_b_valid),
        .s_axi_b_resp_o   (m_b_resp),
        .s_axi_b_ready_i  (m_b_ready),
        .s_axi_ar_valid_i (m_ar_valid),
        .s_axi_ar_addr_i  (m_ar_addr),
        .s_axi_ar_ready_o (m_ar_ready),
        .s_axi_r_valid_o  (m_r_valid),
        .s_axi_r_resp_o   (m_r_resp),
        .s_axi_r_data_o   (m_r_data),
        .s_axi_r_ready_i  (m_r_ready)
    );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker
    import mem_pkg::*;
#(
    parameter int ADDR_W    = ADDR_W_DEF,
    parameter int DATA_W    = DATA_W_DEF,
    parameter int MEM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [1:0]               ar_valid_i,
    input  logic [1:0]               ar_ready_i,
    input  logic [1:0][ADDR_W-1:0]   ar_addr_i,
    input  logic [1:0]               r_valid_i,
    input  logic [1:0]               r_ready_i,
    input  logic [1:0][DATA_W-1:0]   r_data_i,
    input  logic [1:0][1:0]          r_resp_i,
    input  logic [1:0]               aw_valid_i,
    input  logic [1:0]               aw_ready_i,
    input  logic [1:0][ADDR_W-1:0]   aw_addr_i,
    input  logic [1:0]               w_ready_i,
    input  logic [1:0][DATA_W-1:0]   w_data_i,
    input  logic [1:0][DATA_W/8-1:0] w_strb_i,
    input  logic [1:0]               b_valid_i,
    input  logic [1:0]               b_ready_i,
    input  logic [1:0][1:0]          b_resp_i,
    output int                       errors_o
);

    localparam int STRB_W = DATA_W / 8;
    localparam int OFFS_W = $clog2(STRB_W);
    localparam int MEM_AW = $clog2(MEM_DEPTH);

    logic [DATA_W-1:0]        shadow [MEM_DEPTH];
    logic [1:0][ADDR_W-1:0]   rd_addr, wr_addr;
    logic [1:0][DATA_W-1:0]   wr_data, r_data_q;
    logic [1:0][STRB_W-1:0]   wr_strb;
    logic [1:0][1:0]          r_resp_q, b_resp_q;
    logic [1:0]               r_stall, b_stall;
    logic                     rst_d = 1'b0;
    logic                     rd_wait = 1'b0;
    logic                     wr_wait = 1'b0;
    int                       last_rd = -1;
    int                       last_wr = -1;
    int                       err_cnt = 0;

    assign errors_o = err_cnt;

    function automatic logic in_range(input logic [ADDR_W-1:0] addr);
        return (addr >> OFFS_W) < ADDR_W'(MEM_DEPTH);
    endfunction

    task automatic mismatch(input string sig, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] got);
        $display("ERROR %0t %s expected %h got %h", $time, sig, exp, got);
        err_cnt++;
    endtask

    task automatic expect_low(input string sig, input logic val);
        if (val !== 1'b0) begin
            mismatch(sig, '0, DATA_W'(val));
        end
    endtask

    task automatic order_error(input int m, input string kind);
        $display("ERROR %0t s%0d completed two %s in a row while s%0d was waiting",
                 $time, m + 1, kind, 2 - m);
        err_cnt++;
    endtask

    always @(posedge clk) begin
        logic [ADDR_W-1:0] widx;
        logic [DATA_W-1:0] exp_data;
        resp_t             exp_resp;
        logic              exp_w_ready;
        string             pfx;
        for (int m = 0; m < 2; m++) begin
            pfx = $sformatf("s%0d_axi_", m + 1);
            if (rst_d) begin
                expect_low({pfx, "ar_ready_o"}, ar_ready_i[m]);
                expect_low({pfx, "aw_ready_o"}, aw_ready_i[m]);
                expect_low({pfx, "w_ready_o"}, w_ready_i[m]);
                expect_low({pfx, "r_valid_o"}, r_valid_i[m]);
                expect_low({pfx, "b_valid_o"}, b_valid_i[m]);
            end else begin
                // A stalled response holds its payload
                if (r_stall[m]) begin
                    if (r_valid_i[m] !== 1'b1) begin
                        mismatch({pfx, "r_valid_o"}, 1, DATA_W'(r_valid_i[m]));
                    end
                    if (r_data_i[m] !== r_data_q[m]) begin
                        mismatch({pfx, "r_data_o"}, r_data_q[m], r_data_i[m]);
                    end
                    if (r_resp_i[m] !== r_resp_q[m]) begin
                        mismatch({pfx, "r_resp_o"}, DATA_W'(r_resp_q[m]), DATA_W'(r_resp_i[m]));
                    end
                end
                if (b_stall[m]) begin
                    if (b_valid_i[m] !== 1'b1) begin
                        mismatch({pfx, "b_valid_o"}, 1, DATA_W'(b_valid_i[m]));
                    end
                    if (b_resp_i[m] !== b_resp_q[m]) begin
                        mismatch({pfx, "b_resp_o"}, DATA_W'(b_resp_q[m]), DATA_W'(b_resp_i[m]));
                    end
                end
                // W is taken in the same cycle as AW
                exp_w_ready = aw_valid_i[m] && aw_ready_i[m];
                if (w_ready_i[m] !== exp_w_ready) begin
                    mismatch({pfx, "w_ready_o"}, DATA_W'(exp_w_ready), DATA_W'(w_ready_i[m]));
                end
                if (ar_valid_i[m] && ar_ready_i[m]) begin
                    rd_addr[m] = ar_addr_i[m];
                end
                if (aw_valid_i[m] && aw_ready_i[m]) begin
                    wr_addr[m] = aw_addr_i[m];
                    wr_data[m] = w_data_i[m];
                    wr_strb[m] = w_strb_i[m];
                end
                if (r_valid_i[m] && r_ready_i[m]) begin
                    widx     = rd_addr[m] >> OFFS_W;
                    exp_resp = in_range(rd_addr[m]) ? RESP_OKAY : RESP_SLVERR;
                    exp_data = in_range(rd_addr[m]) ? shadow[widx[MEM_AW-1:0]] : '0;
                    if (r_resp_i[m] !== exp_resp) begin
                        mismatch({pfx, "r_resp_o"}, DATA_W'(exp_resp), DATA_W'(r_resp_i[m]));
                    end
                    if (r_data_i[m] !== exp_data) begin
                        mismatch({pfx, "r_data_o"}, exp_data, r_data_i[m]);
                    end
                    if (last_rd == m && rd_wait) order_error(m, "reads");
                    last_rd = m;
                    rd_wait = ar_valid_i[1 - m];
                end
                if (b_valid_i[m] && b_ready_i[m]) begin
                    widx     = wr_addr[m] >> OFFS_W;
                    exp_resp = in_range(wr_addr[m]) ? RESP_OKAY : RESP_SLVERR;
                    if (b_resp_i[m] !== exp_resp) begin
                        mismatch({pfx, "b_resp_o"}, DATA_W'(exp_resp), DATA_W'(b_resp_i[m]));
                    end
                    // Shadow follows the strobed bytes of in-range writes
                    for (int b = 0; b < STRB_W; b++) begin
                        if (in_range(wr_addr[m]) && wr_strb[m][b]) begin
                            shadow[widx[MEM_AW-1:0]][b*8 +: 8] = wr_data[m][b*8 +: 8];
                        end
                    end
                    if (last_wr == m && wr_wait) order_error(m, "writes");
                    last_wr = m;
                    wr_wait = aw_valid_i[1 - m];
                end
            end
            r_stall[m]  = r_valid_i[m] && !r_ready_i[m];
            b_stall[m]  = b_valid_i[m] && !b_ready_i[m];
            r_data_q[m] = r_data_i[m];
            r_resp_q[m] = r_resp_i[m];
            b_resp_q[m] = b_resp_i[m];
        end
        // Single read path gives one response at a time
        if (!rst_d && r_valid_i === 2'b11) begin
            mismatch("s2_axi_r_valid_o", '0, 1);
        end
        rst_d = rst;
    end

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int ADDR_W    = ADDR_W_DEF;
    localparam int DATA_W    = DATA_W_DEF;
    localparam int STRB_W    = DATA_W / 8;
    localparam int MEM_DEPTH = 256;
    localparam int HALF      = MEM_DEPTH / 2;
    localparam int TIMEOUT   = 100;

    localparam int AR_READY = 0;
    localparam int R_VALID  = 1;
    localparam int AW_READY = 2;
    localparam int B_VALID  = 3;

    logic                   clk;
    logic                   rst;
    logic [1:0]             ar_valid, r_ready, aw_valid, w_valid, b_ready;
    logic [1:0][ADDR_W-1:0] ar_addr, aw_addr;
    logic [1:0][DATA_W-1:0] w_data;
    logic [1:0][STRB_W-1:0] w_strb;
    wire  [1:0]             ar_ready, aw_ready, w_ready, r_valid, b_valid;
    wire  [1:0][DATA_W-1:0] r_data;
    wire  [1:0][1:0]        r_resp, b_resp;
    int                     errors;
    int                     seed = 35;
    int                     timeouts = 0;
    int                     err_mark = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Index 0 is the fetch port s1, index 1 the load/store port s2
    mem_subsys #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_dut (
        .clk               (clk),
        .rst               (rst),
        .s1_axi_aw_valid_i (aw_valid[0]),
        .s1_axi_aw_addr_i  (aw_addr[0]),
        .s1_axi_aw_ready_o (aw_ready[0]),
        .s1_axi_w_valid_i  (w_valid[0]),
        .s1_axi_w_data_i   (w_data[0]),
        .s1_axi_w_strb_i   (w_strb[0]),
        .s1_axi_w_ready_o  (w_ready[0]),
        .s1_axi_b_ready_i  (b_ready[0]),
        .s1_axi_b_valid_o  (b_valid[0]),
        .s1_axi_b_resp_o   (b_resp[0]),
        .s1_axi_ar_valid_i (ar_valid[0]),
        .s1_axi_ar_addr_i  (ar_addr[0]),
        .s1_axi_ar_ready_o (ar_ready[0]),
        .s1_axi_r_ready_i  (r_ready[0]),
        .s1_axi_r_valid_o  (r_valid[0]),
        .s1_axi_r_resp_o   (r_resp[0]),
        .s1_axi_r_data_o   (r_data[0]),
        .s2_axi_aw_valid_i (aw_valid[1]),
        .s2_axi_aw_addr_i  (aw_addr[1]),
        .s2_axi_aw_ready_o (aw_ready[1]),
        .s2_axi_w_valid_i  (w_valid[1]),
        .s2_axi_w_data_i   (w_data[1]),
        .s2_axi_w_strb_i   (w_strb[1]),
        .s2_axi_w_ready_o  (w_ready[1]),
        .s2_axi_b_ready_i  (b_ready[1]),
        .s2_axi_b_valid_o  (b_valid[1]),
        .s2_axi_b_resp_o   (b_resp[1]),
        .s2_axi_ar_valid_i (ar_valid[1]),
        .s2_axi_ar_addr_i  (ar_addr[1]),
        .s2_axi_ar_ready_o (ar_ready[1]),
        .s2_axi_r_ready_i  (r_ready[1]),
        .s2_axi_r_valid_o  (r_valid[1]),
        .s2_axi_r_resp_o   (r_resp[1]),
        .s2_axi_r_data_o   (r_data[1])
    );

    tb_checker #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_checker (
        .clk        (clk),
        .rst        (rst),
        .ar_valid_i (ar_valid),
        .ar_ready_i (ar_ready),
        .ar_addr_i  (ar_addr),
        .r_valid_i  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_i   (r_data),
        .r_resp_i   (r_resp),
        .aw_valid_i (aw_valid),
        .aw_ready_i (aw_ready),
        .aw_addr_i  (aw_addr),
        .w_ready_i  (w_ready),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .b_valid_i  (b_valid),
        .b_ready_i  (b_ready),
        .b_resp_i   (b_resp),
        .errors_o   (errors)
    );

    function automatic logic flag(input int kind, input int m);
        case (kind)
            AR_READY: return ar_ready[m];
            R_VALID:  return r_valid[m];
            AW_READY: return aw_ready[m];
            default:  return b_valid[m];
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] own_addr(input int m);
        int w;
        w = m * HALF + {$random(seed)} % HALF;
        return ADDR_W'(w * STRB_W);
    endfunction

    function automatic logic [DATA_W-1:0] rand_data();
        return DATA_W'({$random(seed), $random(seed)});
    endfunction

    // Returns on the rising edge where the flag is seen high
    task automatic wait_flag(input int kind, input int m, input string what, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            ok = flag(kind, m);
        end
        if (!ok) begin
            $display("Timeout: s%0d waited %0d cycles for %s", m + 1, TIMEOUT, what);
            timeouts++;
        end
    endtask

    // Called on a rising edge, returns on the edge of the final handshake
    task automatic read_word(input int m, input logic [ADDR_W-1:0] addr, input int hold);
        logic ok;
        ar_valid[m] <= 1'b1;
        ar_addr[m]  <= addr;
        r_ready[m]  <= (hold == 0);
        wait_flag(AR_READY, m, "ar_ready", ok);
        ar_valid[m] <= 1'b0;
        if (ok) begin
            wait_flag(R_VALID, m, "r_valid", ok);
        end
        if (ok && hold > 0) begin
            repeat (hold) @(posedge clk);
            r_ready[m] <= 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic write_word(input int m, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        logic ok;
        aw_valid[m] <= 1'b1;
        w_valid[m]  <= 1'b1;
        aw_addr[m]  <= addr;
        w_data[m]   <= data;
        w_strb[m]   <= strb;
        wait_flag(AW_READY, m, "aw_ready", ok);
        aw_valid[m] <= 1'b0;
        w_valid[m]  <= 1'b0;
        if (ok) begin
            wait_flag(B_VALID, m, "b_valid", ok);
        end
    endtask

    // Each master fills its own half so every later read is defined
    task automatic fill_and_check(input int m);
        for (int i = 0; i < HALF; i++) begin
            write_word(m, ADDR_W'((m * HALF + i) * STRB_W), rand_data(), '1);
        end
        repeat (32) read_word(m, own_addr(m), 0);
    endtask

    task automatic partial_strobes(input int m);
        logic [ADDR_W-1:0] a;
        repeat (24) begin
            a = own_addr(m);
            write_word(m, a, rand_data(), STRB_W'($random(seed)));
            read_word(m, a, 0);
        end
    endtask

    // Out-of-range word aliases onto an own word if the decode truncates
    task automatic out_of_range(input int m);
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] oor;
        repeat (8) begin
            a   = own_addr(m);
            oor = a + ADDR_W'(MEM_DEPTH * STRB_W * (1 + {$random(seed)} % 3));
            write_word(m, oor, rand_data(), '1);
            read_word(m, oor, 0);
            read_word(m, a, 0);
        end
    endtask

    task automatic back_to_back(input int m, input logic is_write);
        repeat (20) begin
            if (is_write) begin
                write_word(m, own_addr(m), rand_data(), '1);
            end else begin
                read_word(m, own_addr(m), 0);
            end
        end
    endtask

    // The first master holds r_ready low, the other requests one cycle later
    task automatic held_read(input int m, input int lag);
        repeat (lag) @(posedge clk);
        read_word(m, own_addr(m), (lag == 0) ? 3 + {$random(seed)} % 8 : 0);
    endtask

    task automatic end_test(input string name);
        int errs;
        repeat (2) @(posedge clk);
        errs = errors + timeouts;
        if (errs == err_mark) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errs - err_mark);
        end
        err_mark = errs;
    endtask

    initial begin
        rst      = 1'b1;
        ar_valid = '0;
        ar_addr  = '0;
        r_ready  = '1;
        aw_valid = '0;
        aw_addr  = '0;
        w_valid  = '0;
        w_data   = '0;
        w_strb   = '0;
        b_ready  = '1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        end_test("reset");
        fork
            fill_and_check(0);
            fill_and_check(1);
        join
        end_test("write_readback");
        fork
            partial_strobes(0);
            partial_strobes(1);
        join
        end_test("partial_strobes");
        fork
            out_of_range(0);
            out_of_range(1);
        join
        end_test("out_of_range");
        fork
            back_to_back(0, 1'b0);
            back_to_back(1, 1'b0);
        join
        fork
            back_to_back(0, 1'b1);
            back_to_back(1, 1'b1);
        join
        end_test("contention");
        for (int k = 0; k < 6; k++) begin
            fork
                held_read(k % 2, 0);
                held_read(1 - k % 2, 1);
            join
        end
        end_test("back_pressure");
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
